// File: sources.f
+incdir+include
hw/lbp_pkg.sv
hw/resize_tracker.sv
hw/window_buffer.sv
hw/lbp_classifier.sv
hw/lbp_detector.sv
bench/lbp_detector_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the LBP detector testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f sources.f \
	--top-module lbp_detector_tb \
	-o sim_lbp_detector

./obj_dir/sim_lbp_detector | tee sim.log

if grep -q "Test completed successfully" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// File: bench/lbp_detector_tb.sv
`timescale 1ns/1ns
`include "lbp_macros.svh"

module lbp_detector_tb;

	localparam int SHIFT = `LBP_RESIZE_SHIFT;
	localparam int RES_W = `LBP_RESIZE_WIDTH;
	localparam int ORI_W = RES_W << SHIFT; // original frame is square
	localparam int PIXELS = ORI_W * ORI_W;
	localparam int WINDOWS = (RES_W - 2) * (RES_W - 2);
	localparam int MAX_DB = 16;
	localparam int FRAMES = 5;
	localparam int TIMEOUT_CYCLES = FRAMES * (PIXELS + WINDOWS * (MAX_DB + 4)) + 50;
	localparam int MODE_RANDOM = 0;
	localparam int MODE_ACCEPT = 1;
	localparam int MODE_REJECT = 2;
	localparam int MODE_STRAY = 3;

	logic clk_fpga;
	logic reset_fpga;
	logic i_pixel_valid;
	lbp_pkg::pixel_t i_pixel;
	lbp_pkg::coord_t i_ori_x;
	lbp_pkg::coord_t i_ori_y;
	logic i_db_valid;
	lbp_pkg::lbp_code_t i_db_code;
	lbp_pkg::weight_t i_db_weight;
	lbp_pkg::score_t i_db_threshold;
	logic i_db_last_in_stage;
	logic i_db_last_stage;
	logic o_pixel_request;
	logic o_database_request;
	logic o_inspect_done;
	logic o_candidate;
	lbp_pkg::coord_t o_resize_x;
	lbp_pkg::coord_t o_resize_y;

	lbp_pkg::pixel_t frame_model [RES_W][RES_W]; // resized frame as sent
	lbp_pkg::lbp_code_t db_code [MAX_DB];
	lbp_pkg::weight_t db_weight [MAX_DB];
	lbp_pkg::score_t db_thr [MAX_DB];
	logic db_lis [MAX_DB];
	logic db_ls [MAX_DB];
	int db_len;

	logic exp_candidate = 1'b0;
	lbp_pkg::coord_t exp_x = '0;
	lbp_pkg::coord_t exp_y = '0;
	logic awaiting = 1'b0; // window completing pixel sent and no decision seen yet
	logic decide_pending = 1'b0;
	int last_x;
	int last_y;
	int done_count = 0;
	int error_count = 0;
	int test_errors_start = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycle_count = 0;

	lbp_detector i_lbp_detector
	(
		.clk_fpga           (clk_fpga),
		.reset_fpga         (reset_fpga),
		.i_pixel_valid      (i_pixel_valid),
		.i_pixel            (i_pixel),
		.i_ori_x            (i_ori_x),
		.i_ori_y            (i_ori_y),
		.i_db_valid         (i_db_valid),
		.i_db_code          (i_db_code),
		.i_db_weight        (i_db_weight),
		.i_db_threshold     (i_db_threshold),
		.i_db_last_in_stage (i_db_last_in_stage),
		.i_db_last_stage    (i_db_last_stage),
		.o_pixel_request    (o_pixel_request),
		.o_database_request (o_database_request),
		.o_inspect_done     (o_inspect_done),
		.o_candidate        (o_candidate),
		.o_resize_x         (o_resize_x),
		.o_resize_y         (o_resize_y)
	);

	initial clk_fpga = 1'b0;
	always #5 clk_fpga = ~clk_fpga;

	always @(posedge clk_fpga)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles with the DUT stalled", cycle_count);
			$display("Test failed");
			$finish;
		end
	end

	a_reset_outputs: assert property (@(posedge clk_fpga)
		reset_fpga |=> (o_pixel_request && !o_database_request &&
			!o_inspect_done && !o_candidate))
	else
	begin
		error_count = error_count + 1;
		$write("** Error: after reset o_pixel_request = %h, o_database_request = %h, ",
			$sampled(o_pixel_request), $sampled(o_database_request));
		$display("o_inspect_done = %h, o_candidate = %h, expected 1 0 0 0",
			$sampled(o_inspect_done), $sampled(o_candidate));
	end

	a_requests_exclusive: assert property (@(posedge clk_fpga) disable iff (reset_fpga)
		!(o_pixel_request && o_database_request))
	else
	begin
		error_count = error_count + 1;
		$display("pixel and database requests were both high at the same time");
	end

	a_candidate: assert property (@(posedge clk_fpga) disable iff (reset_fpga)
		o_inspect_done |-> (o_candidate == exp_candidate))
	else
	begin
		error_count = error_count + 1;
		$display("** Error: o_candidate = %h, expected %h",
			$sampled(o_candidate), exp_candidate);
	end

	a_resize_x: assert property (@(posedge clk_fpga) disable iff (reset_fpga)
		o_inspect_done |-> (o_resize_x == exp_x))
	else
	begin
		error_count = error_count + 1;
		$display("** Error: o_resize_x = %h, expected %h", $sampled(o_resize_x), exp_x);
	end

	a_resize_y: assert property (@(posedge clk_fpga) disable iff (reset_fpga)
		o_inspect_done |-> (o_resize_y == exp_y))
	else
	begin
		error_count = error_count + 1;
		$display("** Error: o_resize_y = %h, expected %h", $sampled(o_resize_y), exp_y);
	end

	a_candidate_with_done: assert property (@(posedge clk_fpga) disable iff (reset_fpga)
		o_candidate |-> o_inspect_done)
	else
	begin
		error_count = error_count + 1;
		$display("o_candidate was raised without o_inspect_done");
	end

	// the deciding entry is followed at once by the decision and no further request
	a_decision_timing: assert property (@(posedge clk_fpga) disable iff (reset_fpga)
		decide_pending |=> (o_inspect_done && !o_database_request))
	else
	begin
		error_count = error_count + 1;
		$write("** Error: after the deciding entry o_inspect_done = %h, ",
			$sampled(o_inspect_done));
		$display("o_database_request = %h, expected 1 0", $sampled(o_database_request));
	end

	a_done_after_decision: assert property (@(posedge clk_fpga) disable iff (reset_fpga)
		o_inspect_done |-> $past(decide_pending))
	else
	begin
		error_count = error_count + 1;
		$display("o_inspect_done came without the deciding database entry just before it");
	end

	a_pixel_hold: assert property (@(posedge clk_fpga) disable iff (reset_fpga)
		awaiting |=> (!o_pixel_request || o_inspect_done))
	else
	begin
		error_count = error_count + 1;
		$display("o_pixel_request went high while a window was still being inspected");
	end

	// neighbours run clockwise from top-left with bit 7 first
	function automatic lbp_pkg::lbp_code_t expected_code(input int cx, input int cy);
		int dx [8] = '{-1, 0, 1, 1, 1, 0, -1, -1};
		int dy [8] = '{-1, -1, -1, 0, 1, 1, 1, 0};
		lbp_pkg::lbp_code_t code;
		for (int i = 0; i < 8; i++)
			code[7-i] = (frame_model[cy+dy[i]][cx+dx[i]] >= frame_model[cy][cx]);
		return code;
	endfunction

	// returns the index of the entry that settles the window
	function automatic int evaluate_cascade(input lbp_pkg::lbp_code_t code, output logic cand);
		int score;
		score = 0;
		cand = 1'b0;
		for (int i = 0; i < db_len; i++)
		begin
			if (db_code[i] == code)
				score += int'(db_weight[i]);
			if (db_lis[i])
			begin
				if (score < int'(db_thr[i]))
					return i;
				if (db_ls[i])
				begin
					cand = 1'b1;
					return i;
				end
				score = 0; // next stage starts from nothing
			end
		end
		return db_len - 1;
	endfunction

	task automatic build_database(input int mode, input lbp_pkg::lbp_code_t code);
		int stages;
		int per_stage;
		int n;
		stages = (mode == MODE_ACCEPT) ? 1 : 3;
		per_stage = (mode == MODE_ACCEPT) ? 1 : ((mode == MODE_REJECT) ? 2 : 3);
		n = 0;
		for (int s = 0; s < stages; s++)
		begin
			for (int e = 0; e < per_stage; e++)
			begin
				db_weight[n] = lbp_pkg::weight_t'($urandom);
				db_thr[n] = lbp_pkg::score_t'($urandom % 300);
				if (mode == MODE_ACCEPT)
				begin
					db_weight[n] = lbp_pkg::weight_t'(1 + $urandom % 255);
					db_code[n] = code;
					db_thr[n] = lbp_pkg::score_t'(db_weight[n]);
				end
				else if (mode == MODE_REJECT && s == 0)
				begin
					// never matches
					db_code[n] = code ^ lbp_pkg::lbp_code_t'(1 + $urandom % 255);
					db_thr[n] = lbp_pkg::score_t'(1 + $urandom % 200);
				end
				else if ($urandom % 2 == 0)
					db_code[n] = code;
				else
					db_code[n] = lbp_pkg::lbp_code_t'($urandom);
				db_lis[n] = (e == per_stage - 1);
				db_ls[n] = (s == stages - 1);
				n++;
			end
		end
		db_len = n;
	endtask

	task automatic run_frame(input int mode);
		int pix_idx;
		int db_idx;
		int decide_idx;
		int ox;
		int oy;
		logic db_built;
		logic frame_done;
		pix_idx = 0;
		db_idx = 0;
		decide_idx = 0;
		db_built = 1'b0;
		frame_done = 1'b0;
		done_count = 0;
		while (!frame_done)
		begin
			@(negedge clk_fpga);
			if (o_inspect_done)
			begin
				done_count++;
				awaiting = 1'b0;
				db_built = 1'b0;
			end
			i_pixel_valid = 1'b0;
			if (o_pixel_request && pix_idx < PIXELS)
			begin
				ox = pix_idx % ORI_W;
				oy = pix_idx / ORI_W;
				i_pixel_valid = 1'b1;
				i_pixel = lbp_pkg::pixel_t'($urandom);
				i_ori_x = lbp_pkg::coord_t'(ox);
				i_ori_y = lbp_pkg::coord_t'(oy);
				if ((ox % (1 << SHIFT)) == 0 && (oy % (1 << SHIFT)) == 0)
				begin
					last_x = ox >> SHIFT;
					last_y = oy >> SHIFT;
					frame_model[last_y][last_x] = i_pixel;
					if (last_x >= 2 && last_y >= 2)
						awaiting = 1'b1;
				end
				pix_idx++;
			end
			else if (o_pixel_request)
				frame_done = 1'b1;
			else if (mode == MODE_STRAY)
			begin
				i_pixel_valid = 1'b1; // would land on the grid if it got through
				i_pixel = lbp_pkg::pixel_t'($urandom);
				i_ori_x = lbp_pkg::coord_t'(($urandom % RES_W) << SHIFT);
				i_ori_y = lbp_pkg::coord_t'(($urandom % RES_W) << SHIFT);
			end
			i_db_valid = 1'b0;
			decide_pending = 1'b0;
			if (o_database_request)
			begin
				if (!db_built)
				begin
					build_database(mode, expected_code(last_x - 1, last_y - 1));
					decide_idx = evaluate_cascade(expected_code(last_x - 1, last_y - 1),
						exp_candidate);
					exp_x = lbp_pkg::coord_t'(last_x);
					exp_y = lbp_pkg::coord_t'(last_y);
					db_idx = 0;
					db_built = 1'b1;
				end
				if (db_idx < db_len)
				begin
					i_db_valid = 1'b1;
					i_db_code = db_code[db_idx];
					i_db_weight = db_weight[db_idx];
					i_db_threshold = db_thr[db_idx];
					i_db_last_in_stage = db_lis[db_idx];
					i_db_last_stage = db_ls[db_idx];
					decide_pending = (db_idx == decide_idx);
					db_idx++;
				end
				else
				begin
					error_count = error_count + 1;
					$display("database ran out and the DUT still asked for entries");
				end
			end
			else if (mode == MODE_STRAY)
			begin
				i_db_valid = 1'b1; // decisive entry outside the request
				i_db_code = lbp_pkg::lbp_code_t'($urandom);
				i_db_weight = lbp_pkg::weight_t'($urandom);
				i_db_threshold = '0;
				i_db_last_in_stage = 1'b1;
				i_db_last_stage = 1'b1;
			end
		end
		i_pixel_valid = 1'b0;
		i_db_valid = 1'b0;
		assert (done_count == WINDOWS)
		else
		begin
			error_count = error_count + 1;
			$display("** Error: done_count = %h, expected %h", done_count, WINDOWS);
		end
	endtask

	task automatic report_test(input string name);
		int errs;
		errs = error_count - test_errors_start;
		tests_run++;
		if (errs != 0)
			tests_failed++;
		$display("test %0d %s: %0d inspections, %0d errors",
			tests_run, name, done_count, errs);
		test_errors_start = error_count;
	endtask

	initial
	begin
		void'($urandom(50850));
		reset_fpga = 1'b1;
		i_pixel_valid = 1'b0;
		i_pixel = '0;
		i_ori_x = '0;
		i_ori_y = '0;
		i_db_valid = 1'b0;
		i_db_code = '0;
		i_db_weight = '0;
		i_db_threshold = '0;
		i_db_last_in_stage = 1'b0;
		i_db_last_stage = 1'b0;
		repeat (3) @(posedge clk_fpga);
		@(negedge clk_fpga);
		reset_fpga = 1'b0;
		repeat (2) @(negedge clk_fpga);
		report_test("reset state");
		run_frame(MODE_RANDOM);
		report_test("decimation");
		run_frame(MODE_ACCEPT);
		report_test("single-stage accept");
		run_frame(MODE_REJECT);
		report_test("early reject");
		run_frame(MODE_RANDOM);
		report_test("multi-stage accept");
		run_frame(MODE_STRAY);
		report_test("request exclusivity");
		repeat (2) @(negedge clk_fpga);
		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
			error_count);
		if (error_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: hw/lbp_detector.sv
`timescale 1ns/1ns
`include "lbp_macros.svh"

module lbp_detector
(
	input  logic               clk_fpga,
	input  logic               reset_fpga,
	input  logic               i_pixel_valid,
	input  lbp_pkg::pixel_t    i_pixel,
	input  lbp_pkg::coord_t    i_ori_x,
	input  lbp_pkg::coord_t    i_ori_y,
	input  logic               i_db_valid,
	input  lbp_pkg::lbp_code_t i_db_code,
	input  lbp_pkg::weight_t   i_db_weight,
	input  lbp_pkg::score_t    i_db_threshold,
	input  logic               i_db_last_in_stage,
	input  logic               i_db_last_stage,
	output logic               o_pixel_request,
	output logic               o_database_request,
	output logic               o_inspect_done,
	output logic               o_candidate,
	output lbp_pkg::coord_t    o_resize_x,
	output lbp_pkg::coord_t    o_resize_y
);

	lbp_pkg::det_state_t state;
	lbp_pkg::det_state_t next_state;
	lbp_pkg::coord_t column;
	lbp_pkg::window_t window;
	logic reach;
	logic write;
	logic window_complete;
	logic db_valid;

	// the decision cycle already hands the stream back to the pixel side
	assign o_pixel_request = ((state == lbp_pkg::ST_FILL) && !window_complete) ||
		((state == lbp_pkg::ST_INSPECT) && o_inspect_done);
	assign o_database_request = (state == lbp_pkg::ST_INSPECT) && !o_inspect_done;

	assign write    = i_pixel_valid && o_pixel_request && reach;
	assign db_valid = i_db_valid && o_database_request; // strobes outside a request drop here
	assign column   = i_ori_x >> `LBP_RESIZE_SHIFT;

	always_ff @(posedge clk_fpga)
	begin
		if (reset_fpga)
			state <= lbp_pkg::ST_FILL;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			lbp_pkg::ST_FILL:
			begin
				if (window_complete)
					next_state = lbp_pkg::ST_INSPECT;
			end
			lbp_pkg::ST_INSPECT:
			begin
				if (o_inspect_done)
					next_state = lbp_pkg::ST_FILL;
			end
			default:
				next_state = lbp_pkg::ST_FILL;
		endcase
	end

	resize_tracker i_resize_tracker
	(
		.clk_fpga          (clk_fpga),
		.reset_fpga        (reset_fpga),
		.i_write           (write),
		.i_ori_x           (i_ori_x),
		.i_ori_y           (i_ori_y),
		.o_reach           (reach),
		.o_resize_x        (o_resize_x),
		.o_resize_y        (o_resize_y),
		.o_window_complete (window_complete)
	);

	window_buffer i_window_buffer
	(
		.clk_fpga   (clk_fpga),
		.reset_fpga (reset_fpga),
		.i_write    (write),
		.i_pixel    (i_pixel),
		.i_column   (column),
		.o_window   (window)
	);

	lbp_classifier i_lbp_classifier
	(
		.clk_fpga           (clk_fpga),
		.reset_fpga         (reset_fpga),
		.i_start            (window_complete), // one pulse per finished window
		.i_window           (window),
		.i_db_valid         (db_valid),
		.i_db_code          (i_db_code),
		.i_db_weight        (i_db_weight),
		.i_db_threshold     (i_db_threshold),
		.i_db_last_in_stage (i_db_last_in_stage),
		.i_db_last_stage    (i_db_last_stage),
		.o_inspect_done     (o_inspect_done),
		.o_candidate        (o_candidate)
	);

	a_request_exclusive: assert property (@(posedge clk_fpga) disable iff (reset_fpga)
		!(o_pixel_request && o_database_request));

endmodule

// File: hw/lbp_classifier.sv
`timescale 1ns/1ns
`include "lbp_macros.svh"

module lbp_classifier
(
	input  logic               clk_fpga,
	input  logic               reset_fpga,
	input  logic               i_start,
	input  lbp_pkg::window_t   i_window,
	input  logic               i_db_valid,
	input  lbp_pkg::lbp_code_t i_db_code,
	input  lbp_pkg::weight_t   i_db_weight,
	input  lbp_pkg::score_t    i_db_threshold,
	input  logic               i_db_last_in_stage,
	input  logic               i_db_last_stage,
	output logic               o_inspect_done,
	output logic               o_candidate
);

	lbp_pkg::lbp_code_t code_q;
	lbp_pkg::score_t score_q;
	lbp_pkg::score_t score_next;
	logic [$clog2(`LBP_MAX_STAGES+1)-1:0] stage_q;
	logic busy;
	logic match;

	function automatic lbp_pkg::lbp_code_t lbp_code(input lbp_pkg::window_t win);
		lbp_pkg::pixel_t p [9];
		lbp_pkg::lbp_code_t code;
		for (int i = 0; i < 9; i++)
			p[i] = win[i*`LBP_PIXEL_W +: `LBP_PIXEL_W];
		// clockwise from top-left and compared against the centre
		code[7] = p[0] >= p[4];
		code[6] = p[1] >= p[4];
		code[5] = p[2] >= p[4];
		code[4] = p[5] >= p[4];
		code[3] = p[8] >= p[4];
		code[2] = p[7] >= p[4];
		code[1] = p[6] >= p[4];
		code[0] = p[3] >= p[4];
		return code;
	endfunction

	assign match = (i_db_code == code_q);
	assign score_next = score_q + (match ? lbp_pkg::score_t'(i_db_weight) : '0);

	always_ff @(posedge clk_fpga)
	begin
		if (i_start)
			code_q <= lbp_code(i_window);
	end

	always_ff @(posedge clk_fpga)
	begin
		if (reset_fpga)
		begin
			busy           <= 1'b0;
			score_q        <= '0;
			stage_q        <= '0;
			o_inspect_done <= 1'b0;
			o_candidate    <= 1'b0;
		end
		else
		begin
			o_inspect_done <= 1'b0;
			o_candidate    <= 1'b0;
			if (i_start)
			begin
				busy    <= 1'b1;
				score_q <= '0;
				stage_q <= '0;
			end
			else if (busy && i_db_valid)
			begin
				if (i_db_last_in_stage)
				begin
					if (score_next < i_db_threshold)
					begin
						busy           <= 1'b0; // reject skips the remaining stages
						o_inspect_done <= 1'b1;
					end
					else if (i_db_last_stage)
					begin
						busy           <= 1'b0;
						o_inspect_done <= 1'b1;
						o_candidate    <= 1'b1;
					end
					else
					begin
						score_q <= '0; // each stage scores on its own
						stage_q <= stage_q + 1'b1;
					end
				end
				else
					score_q <= score_next;
			end
		end
	end

	a_stage_bound: assert property (@(posedge clk_fpga) disable iff (reset_fpga)
		stage_q < `LBP_MAX_STAGES);

	// entries only count between a start and its decision
	a_db_in_window: assert property (@(posedge clk_fpga) disable iff (reset_fpga)
		i_db_valid |-> busy);

endmodule

// File: hw/window_buffer.sv
`timescale 1ns/1ns
`include "lbp_macros.svh"

module window_buffer
(
	input  logic             clk_fpga,
	input  logic             reset_fpga,
	input  logic             i_write,
	input  lbp_pkg::pixel_t  i_pixel,
	input  lbp_pkg::coord_t  i_column,
	output lbp_pkg::window_t o_window
);

	localparam int COL_W = $clog2(`LBP_RESIZE_WIDTH);

	lbp_pkg::pixel_t line_mid [`LBP_RESIZE_WIDTH]; // previous resized row
	lbp_pkg::pixel_t line_top [`LBP_RESIZE_WIDTH]; // two rows up
	lbp_pkg::pixel_t win [9];
	lbp_pkg::pixel_t col_top;
	lbp_pkg::pixel_t col_mid;
	logic [COL_W-1:0] col;

	assign col = i_column[COL_W-1:0];

	// older rows at this column are read before the write below replaces them
	assign col_top = line_top[col];
	assign col_mid = line_mid[col];

	// each column is rewritten one resized row later so rows age by themselves
	always_ff @(posedge clk_fpga)
	begin
		if (i_write)
		begin
			line_top[col] <= col_mid;
			line_mid[col] <= i_pixel;
		end
	end

	always_ff @(posedge clk_fpga)
	begin
		if (reset_fpga)
			win <= '{default: '0};
		else if (i_write)
		begin
			for (int r = 0; r < 3; r++)
			begin
				win[3*r]   <= win[3*r+1]; // shift one column left
				win[3*r+1] <= win[3*r+2];
			end
			win[2] <= col_top;
			win[5] <= col_mid;
			win[8] <= i_pixel; // bottom-right is the newest pixel
		end
	end

	always_comb
	begin
		for (int i = 0; i < 9; i++)
			o_window[i*`LBP_PIXEL_W +: `LBP_PIXEL_W] = win[i];
	end

endmodule

// File: hw/resize_tracker.sv
`timescale 1ns/1ns
`include "lbp_macros.svh"

module resize_tracker
(
	input  logic            clk_fpga,
	input  logic            reset_fpga,
	input  logic            i_write,
	input  lbp_pkg::coord_t i_ori_x,
	input  lbp_pkg::coord_t i_ori_y,
	output logic            o_reach,
	output lbp_pkg::coord_t o_resize_x,
	output lbp_pkg::coord_t o_resize_y,
	output logic            o_window_complete
);

	lbp_pkg::coord_t shift_x;
	lbp_pkg::coord_t shift_y;

	assign shift_x = i_ori_x >> `LBP_RESIZE_SHIFT;
	assign shift_y = i_ori_y >> `LBP_RESIZE_SHIFT;

	// only pixels on the decimation grid survive
	assign o_reach = (i_ori_x[`LBP_RESIZE_SHIFT-1:0] == '0) &&
		(i_ori_y[`LBP_RESIZE_SHIFT-1:0] == '0);

	always_ff @(posedge clk_fpga)
	begin
		if (i_write)
		begin
			o_resize_x <= shift_x; // held until the next kept pixel
			o_resize_y <= shift_y;
		end
	end

	// a full 3x3 window needs two older columns and two older rows
	always_ff @(posedge clk_fpga)
	begin
		if (reset_fpga)
			o_window_complete <= 1'b0;
		else
			o_window_complete <= i_write && (shift_x >= 2) && (shift_y >= 2);
	end

	a_column_in_range: assert property (@(posedge clk_fpga) disable iff (reset_fpga)
		i_write |-> (shift_x < `LBP_RESIZE_WIDTH));

endmodule

// File: hw/lbp_pkg.sv
`include "lbp_macros.svh"

package lbp_pkg;

	typedef logic [`LBP_PIXEL_W-1:0] pixel_t;
	typedef logic [`LBP_COORD_W-1:0] coord_t;

	// bit 7 is top-left and the bits run clockwise round to bit 0 at left-middle
	typedef logic [7:0] lbp_code_t;

	typedef logic [`LBP_WEIGHT_W-1:0] weight_t;
	typedef logic [`LBP_SCORE_W-1:0] score_t;

	typedef logic [9*`LBP_PIXEL_W-1:0] window_t; // row-major with the centre at index 4

	typedef enum logic
	{
		ST_FILL,
		ST_INSPECT
	} det_state_t;

endpackage

// File: include/lbp_macros.svh
`ifndef LBP_MACROS_SVH
`define LBP_MACROS_SVH

// datapath widths
`define LBP_PIXEL_W 8
`define LBP_COORD_W 12
`define LBP_WEIGHT_W 8
`define LBP_SCORE_W 12

// decimation as a power of two where 1 keeps every second pixel
`define LBP_RESIZE_SHIFT 1

`define LBP_RESIZE_WIDTH 8 // resized row length and line buffer depth

`define LBP_MAX_STAGES 4 // cascade depth bound

`endif
